// ==== Makefile ====
TOP := tb_rec_buf_pre

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== bank_if.sv ====
// bank_if: write and read signals of the four pixel banks, with modports
`timescale 1ns/1ps

interface bank_if #(
  parameter int PIXEL_WIDTH = 8
) (
  input logic clk
);
  import buf_pkg::*;

  // write side, pixel enables are common to all banks
  logic [WORD_PIX-1:0]             wr_pen;
  bank_adr_t                       wr_adr [NUM_BANKS];
  logic [WORD_PIX*PIXEL_WIDTH-1:0] wr_dat [NUM_BANKS];

  // read side
  logic                            rd_ena;
  bank_adr_t                       rd_adr [NUM_BANKS];
  logic [WORD_PIX*PIXEL_WIDTH-1:0] rd_dat [NUM_BANKS];

  modport wr (
    input  clk,
    output wr_pen,
    output wr_adr,
    output wr_dat
  );

  modport rd (
    output rd_ena,
    output rd_adr,
    input  rd_dat
  );

  modport mem (
    input  wr_pen,
    input  wr_adr,
    input  wr_dat,
    input  rd_ena,
    input  rd_adr,
    output rd_dat
  );

endinterface

// ==== buf_banks.sv ====
// buf_banks: four two-port pixel banks with per-pixel write enables and registered read
`timescale 1ns/1ps

module buf_banks #(
  parameter int PIXEL_WIDTH = 8
) (
  input logic clk,
  bank_if.mem bank
);
  import buf_pkg::*;

  localparam int GRP_W = WORD_PIX * PIXEL_WIDTH;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [GRP_W-1:0] mem [BANK_DEPTH];
    logic [GRP_W-1:0] rd_q;

    // ----------------------------------------
    // write, enabled pixels only
    // ----------------------------------------
    always_ff @(posedge clk) begin
      for (int p = 0; p < WORD_PIX; p++) begin
        if (bank.wr_pen[p]) begin
          mem[bank.wr_adr[b]][p*PIXEL_WIDTH +: PIXEL_WIDTH] <=
            bank.wr_dat[b][p*PIXEL_WIDTH +: PIXEL_WIDTH];
        end
      end
    end

    // read returns old word on a same-cycle write
    always_ff @(posedge clk) begin
      if (bank.rd_ena) begin
        rd_q <= mem[bank.rd_adr[b]];
      end
    end

    assign bank.rd_dat[b] = rd_q;
  end

endmodule

// ==== buf_pkg.sv ====
// block-size enum, bank geometry constants and index types of the pixel buffer
package buf_pkg;

  // ----------------------------------------
  // block size, shared by write and read side
  // ----------------------------------------
  typedef enum logic [1:0] {
    SIZE_04 = 2'd0,
    SIZE_08 = 2'd1,
    SIZE_16 = 2'd2,
    SIZE_32 = 2'd3
  } blk_size_e;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int NUM_BANKS  = 4;
  localparam int BANK_DEPTH = 32;
  localparam int WORD_PIX   = 8;

  // word address is the pixel row
  typedef logic [$clog2(BANK_DEPTH)-1:0] bank_adr_t;

  // coordinate in 4x4 block units
  typedef logic [2:0] blk_pos_t;

  typedef logic [4:0] rd_idx_t;

endpackage

// ==== buf_rd_map.sv ====
// buf_rd_map: bank read addresses, delayed output selector and row-major reorder
`timescale 1ns/1ps

module buf_rd_map #(
  parameter int PIXEL_WIDTH = 8
) (
  input  logic                                                        clk,
  input  logic                                                        rstn,
  input  logic                                                        rd_ena_i,
  input  buf_pkg::blk_size_e                                          rd_siz_i,
  input  buf_pkg::blk_pos_t                                           rd_x_i,
  input  buf_pkg::blk_pos_t                                           rd_y_i,
  input  buf_pkg::rd_idx_t                                            rd_idx_i,
  bank_if.rd                                                          bank,
  output logic [buf_pkg::NUM_BANKS*buf_pkg::WORD_PIX*PIXEL_WIDTH-1:0] rd_dat_o
);
  import buf_pkg::*;

  localparam int GRP_W = WORD_PIX * PIXEL_WIDTH;

  // selector state of the read in flight
  logic                            rd_vld_r;
  blk_size_e                       rd_siz_r;
  logic [1:0]                      rd_x_r;
  logic [1:0]                      rd_idx_r;

  logic [1:0]                      sel_base;
  logic                            sel_rev;
  logic [0:NUM_BANKS-1][GRP_W-1:0] grp;

  assign bank.rd_ena = rd_ena_i;

  // ----------------------------------------
  // read addresses
  // ----------------------------------------
  always_comb begin
    logic [1:0] row_lo;
    for (int b = 0; b < NUM_BANKS; b++) begin
      // 8x8: row that the pair rotation puts on bank b
      row_lo = 2'(b) - {rd_x_i[1], rd_x_i[2]};
      case (rd_siz_i)
        SIZE_32: begin
          bank.rd_adr[b] = rd_idx_i;
        end
        SIZE_16: begin
          // even banks hold the upper row when x[2] is 0
          bank.rd_adr[b] = {rd_y_i[2], rd_idx_i[3:1], b[0] ^ rd_x_i[2]};
        end
        default: begin
          bank.rd_adr[b] = {rd_y_i[2:1], rd_idx_i[2], row_lo};
        end
      endcase
    end
  end

  // ----------------------------------------
  // selector delay, aligned with bank read
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_vld_r <= 1'b0;
      rd_siz_r <= SIZE_32;
      rd_x_r   <= '0;
      rd_idx_r <= '0;
    end else if (rd_ena_i) begin
      rd_vld_r <= 1'b1;
      rd_siz_r <= rd_siz_i;
      rd_x_r   <= rd_x_i[2:1];
      rd_idx_r <= rd_idx_i[1:0];
    end
  end

  // ----------------------------------------
  // output reorder
  // ----------------------------------------
  // group j comes from bank sel_base + j, j bit-reversed for row and 16-wide reads
  always_comb begin
    case (rd_siz_r)
      SIZE_32: begin
        sel_base = rd_idx_r;
        sel_rev  = 1'b1;
      end
      SIZE_16: begin
        sel_base = {rd_idx_r[1], rd_x_r[1]};
        sel_rev  = 1'b1;
      end
      default: begin
        sel_base = {rd_x_r[0], rd_x_r[1]};
        sel_rev  = 1'b0;
      end
    endcase
  end

  always_comb begin
    logic [1:0] grp_idx;
    logic [1:0] bank_sel;
    for (int j = 0; j < NUM_BANKS; j++) begin
      grp_idx  = 2'(j);
      bank_sel = sel_base + (sel_rev ? {grp_idx[0], grp_idx[1]} : grp_idx);
      grp[j]   = bank.rd_dat[bank_sel];
    end
  end

  // zero until the first read returns
  assign rd_dat_o = rd_vld_r ? grp : '0;

  a_no_rd_4x4 : assert property (@(posedge clk) disable iff (!rstn)
    rd_ena_i |-> rd_siz_i != SIZE_04);

  a_no_sel_4x4 : assert property (@(posedge clk) disable iff (!rstn)
    rd_siz_r != SIZE_04);

endmodule

// ==== buf_wr_map.sv ====
// buf_wr_map: pixel enables, rotated bank addresses and rotated data of a block write
`timescale 1ns/1ps

module buf_wr_map #(
  parameter int PIXEL_WIDTH = 8
) (
  input  logic                                                        wr_ena_i,
  input  buf_pkg::blk_size_e                                          wr_siz_i,
  input  buf_pkg::blk_pos_t                                           wr_x_i,
  input  buf_pkg::blk_pos_t                                           wr_y_i,
  input  logic [buf_pkg::NUM_BANKS*buf_pkg::WORD_PIX*PIXEL_WIDTH-1:0] wr_dat_i,
  bank_if.wr                                                          bank
);
  import buf_pkg::*;

  localparam int GRP_W = WORD_PIX * PIXEL_WIDTH;

  // bank offset of the column pair, bit-reversed pair index
  logic [1:0]                      col_rot;
  // grp[0] is the top row of the block
  logic [0:NUM_BANKS-1][GRP_W-1:0] grp;

  assign col_rot = {wr_x_i[1], wr_x_i[2]};
  assign grp     = wr_dat_i;

  // ----------------------------------------
  // pixel enables
  // ----------------------------------------
  always_comb begin
    if (!wr_ena_i) begin
      bank.wr_pen = '0;
    end else if (wr_siz_i != SIZE_04) begin
      bank.wr_pen = '1;
    end else if (wr_x_i[0]) begin
      // right 4 pixels only
      bank.wr_pen = {{(WORD_PIX/2){1'b0}}, {(WORD_PIX/2){1'b1}}};
    end else begin
      bank.wr_pen = {{(WORD_PIX/2){1'b1}}, {(WORD_PIX/2){1'b0}}};
    end
  end

  // ----------------------------------------
  // address and data rotation
  // ----------------------------------------
  // bank b takes the block row that lands on it after rotation
  always_comb begin
    logic [1:0] row_lo;
    for (int b = 0; b < NUM_BANKS; b++) begin
      row_lo         = 2'(b) - col_rot;
      bank.wr_adr[b] = {wr_y_i, row_lo};
      bank.wr_dat[b] = grp[row_lo];
    end
  end

  a_wr_known : assert property (@(posedge bank.clk)
    wr_ena_i |-> !$isunknown({wr_siz_i, wr_x_i, wr_y_i, wr_dat_i}));

endmodule

// ==== rec_buf_pre.sv ====
// rec_buf_pre: 32x32 reconstruction pixel buffer, block write and row/16x16/8x8 read
`timescale 1ns/1ps

module rec_buf_pre #(
  parameter int PIXEL_WIDTH = 8
) (
  input  logic                                                        clk,
  input  logic                                                        rstn,
  // write port
  input  logic                                                        wr_ena_i,
  input  buf_pkg::blk_size_e                                          wr_siz_i,
  input  buf_pkg::blk_pos_t                                           wr_x_i,
  input  buf_pkg::blk_pos_t                                           wr_y_i,
  input  logic [buf_pkg::NUM_BANKS*buf_pkg::WORD_PIX*PIXEL_WIDTH-1:0] wr_dat_i,
  // read port
  input  logic                                                        rd_ena_i,
  input  buf_pkg::blk_size_e                                          rd_siz_i,
  input  buf_pkg::blk_pos_t                                           rd_x_i,
  input  buf_pkg::blk_pos_t                                           rd_y_i,
  input  buf_pkg::rd_idx_t                                            rd_idx_i,
  output logic [buf_pkg::NUM_BANKS*buf_pkg::WORD_PIX*PIXEL_WIDTH-1:0] rd_dat_o
);

  bank_if #(
    .PIXEL_WIDTH (PIXEL_WIDTH)
  ) m_bank (
    .clk (clk)
  );

  // ----------------------------------------
  // write placement
  // ----------------------------------------
  buf_wr_map #(
    .PIXEL_WIDTH (PIXEL_WIDTH)
  ) m_wr_map (
    .wr_ena_i (wr_ena_i),
    .wr_siz_i (wr_siz_i),
    .wr_x_i   (wr_x_i),
    .wr_y_i   (wr_y_i),
    .wr_dat_i (wr_dat_i),
    .bank     (m_bank.wr)
  );

  // ----------------------------------------
  // read addressing and reorder
  // ----------------------------------------
  buf_rd_map #(
    .PIXEL_WIDTH (PIXEL_WIDTH)
  ) m_rd_map (
    .clk      (clk),
    .rstn     (rstn),
    .rd_ena_i (rd_ena_i),
    .rd_siz_i (rd_siz_i),
    .rd_x_i   (rd_x_i),
    .rd_y_i   (rd_y_i),
    .rd_idx_i (rd_idx_i),
    .bank     (m_bank.rd),
    .rd_dat_o (rd_dat_o)
  );

  // storage
  buf_banks #(
    .PIXEL_WIDTH (PIXEL_WIDTH)
  ) m_banks (
    .clk  (clk),
    .bank (m_bank.mem)
  );

endmodule

// ==== sim.f ====
buf_pkg.sv
bank_if.sv
buf_wr_map.sv
buf_rd_map.sv
buf_banks.sv
rec_buf_pre.sv
tb_rec_buf_pre.sv

// ==== tb_rec_buf_pre.sv ====
// testbench of rec_buf_pre with pixel-array reference model, stimulus, read checker and timeout
`timescale 1ns/1ps

module tb_rec_buf_pre;
  import buf_pkg::*;

  localparam int PW         = 8;
  localparam int NUM_COLS   = NUM_BANKS * WORD_PIX;
  localparam int NUM_RAND   = 200;
  // limit well above the roughly 350 cycles of stimulus
  localparam int MAX_CYCLES = 2000;

  typedef logic [NUM_BANKS*WORD_PIX*PW-1:0] pix_vec_t;

  logic      clk;
  logic      rstn;
  logic      wr_ena_i;
  blk_size_e wr_siz_i;
  blk_pos_t  wr_x_i;
  blk_pos_t  wr_y_i;
  pix_vec_t  wr_dat_i;
  logic      rd_ena_i;
  blk_size_e rd_siz_i;
  blk_pos_t  rd_x_i;
  blk_pos_t  rd_y_i;
  rd_idx_t   rd_idx_i;
  pix_vec_t  rd_dat_o;

  // reference image indexed [row][column]
  logic [PW-1:0] pix_model [BANK_DEPTH][NUM_COLS];
  pix_vec_t      exp_pend;
  string         test_name;
  int            n_checks;

  rec_buf_pre #(
    .PIXEL_WIDTH (PW)
  ) i_dut (
    .clk      (clk),
    .rstn     (rstn),
    .wr_ena_i (wr_ena_i),
    .wr_siz_i (wr_siz_i),
    .wr_x_i   (wr_x_i),
    .wr_y_i   (wr_y_i),
    .wr_dat_i (wr_dat_i),
    .rd_ena_i (rd_ena_i),
    .rd_siz_i (rd_siz_i),
    .rd_x_i   (rd_x_i),
    .rd_y_i   (rd_y_i),
    .rd_idx_i (rd_idx_i),
    .rd_dat_o (rd_dat_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // pixel n of a vector is row-major with pixel 0 in the top bits
  function automatic pix_vec_t exp_read(blk_size_e siz, blk_pos_t x, blk_pos_t y, rd_idx_t idx);
    pix_vec_t v;
    int       row0;
    int       col0;
    int       ncol;
    case (siz)
      SIZE_32: begin
        row0 = int'(idx);
        col0 = 0;
        ncol = 32;
      end
      SIZE_16: begin
        row0 = 16 * int'(y[2]) + 2 * int'(idx[3:1]);
        col0 = 16 * int'(x[2]);
        ncol = 16;
      end
      default: begin
        row0 = 8 * int'(y[2:1]) + 4 * int'(idx[2]);
        col0 = 8 * int'(x[2:1]);
        ncol = 8;
      end
    endcase
    for (int n = 0; n < 32; n++) begin
      v[(31-n)*PW +: PW] = pix_model[row0 + n / ncol][col0 + n % ncol];
    end
    return v;
  endfunction

  function automatic void model_write(blk_size_e siz, blk_pos_t x, blk_pos_t y, pix_vec_t dat);
    int row;
    int col;
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 8; k++) begin
        row = 4 * int'(y) + r;
        col = 8 * int'(x[2:1]) + k;
        // 4-wide write keeps the other half
        if (siz != SIZE_04 || (x[0] ? k >= 4 : k < 4)) begin
          pix_model[row][col] = dat[(31 - (8*r + k))*PW +: PW];
        end
      end
    end
  endfunction

  function automatic pix_vec_t rand_pixels();
    pix_vec_t v;
    for (int i = 0; i < $bits(pix_vec_t) / 32; i++) begin
      v[i*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  // ----------------------------------------
  // drivers called right after next_cycle
  // ----------------------------------------
  task automatic next_cycle();
    @(negedge clk);
    wr_ena_i = 1'b0;
    rd_ena_i = 1'b0;
  endtask

  task automatic put_write(blk_size_e siz, blk_pos_t x, blk_pos_t y, pix_vec_t dat);
    wr_ena_i = 1'b1;
    wr_siz_i = siz;
    wr_x_i   = x;
    wr_y_i   = y;
    wr_dat_i = dat;
    model_write(siz, x, y, dat);
  endtask

  // called before put_write in the same cycle so old data is expected
  task automatic put_read(blk_size_e siz, blk_pos_t x, blk_pos_t y, rd_idx_t idx);
    rd_ena_i = 1'b1;
    rd_siz_i = siz;
    rd_x_i   = x;
    rd_y_i   = y;
    rd_idx_i = idx;
    exp_pend = exp_read(siz, x, y, idx);
  endtask

  task automatic check_rd_dat(input string name, input pix_vec_t exp_dat, input pix_vec_t act_dat);
    n_checks++;
    if (act_dat !== exp_dat) begin
      $display("error %s: expected %h actual %h", name, exp_dat, act_dat);
      $display("TESTS FAILED");
      $fatal(1, "read data mismatch");
    end
  endtask

  // ----------------------------------------
  // compare every cycle after reset
  // ----------------------------------------
  initial begin : compare_proc
    pix_vec_t exp_now;
    string    name_now;
    exp_now  = '0;
    name_now = "reset";
    @(posedge rstn);
    forever begin
      @(posedge clk);
      if (rd_ena_i) begin
        exp_now  = exp_pend;
        name_now = test_name;
      end
      @(negedge clk);
      check_rd_dat(name_now, exp_now, rd_dat_o);
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("TESTS FAILED");
        $fatal(1, "timeout after %0d cycles, test sequence did not finish", MAX_CYCLES);
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : stimulus
    int op;
    void'($urandom(52));
    rstn      = 1'b0;
    wr_ena_i  = 1'b0;
    wr_siz_i  = SIZE_08;
    wr_x_i    = '0;
    wr_y_i    = '0;
    wr_dat_i  = '0;
    rd_ena_i  = 1'b0;
    rd_siz_i  = SIZE_32;
    rd_x_i    = '0;
    rd_y_i    = '0;
    rd_idx_i  = '0;
    exp_pend  = '0;
    n_checks  = 0;
    test_name = "reset";
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    next_cycle();

    test_name = "fill_row_read";
    for (int y = 0; y < 8; y++) begin
      for (int xp = 0; xp < 4; xp++) begin
        next_cycle();
        put_write(blk_size_e'($urandom_range(3, 1)), blk_pos_t'(2*xp), blk_pos_t'(y),
                  rand_pixels());
      end
    end
    for (int r = 0; r < 32; r++) begin
      next_cycle();
      put_read(SIZE_32, blk_pos_t'($urandom), blk_pos_t'($urandom), rd_idx_t'(r));
    end

    test_name = "read_8x8";
    for (int xp = 0; xp < 4; xp++) begin
      for (int yp = 0; yp < 4; yp++) begin
        for (int h = 0; h < 2; h++) begin
          next_cycle();
          put_read(SIZE_08, blk_pos_t'(2*xp + $urandom_range(1)),
                   blk_pos_t'(2*yp + $urandom_range(1)), rd_idx_t'(4*h));
        end
      end
    end

    test_name = "read_16x16";
    for (int x2 = 0; x2 < 2; x2++) begin
      for (int y2 = 0; y2 < 2; y2++) begin
        for (int i = 0; i < 8; i++) begin
          next_cycle();
          put_read(SIZE_16, blk_pos_t'(4*x2), blk_pos_t'(4*y2), rd_idx_t'(2*i));
        end
      end
    end

    // left half for even p, right half for odd p
    test_name = "half_write";
    for (int p = 0; p < 4; p++) begin
      next_cycle();
      put_write(SIZE_04, blk_pos_t'(2*p + p%2), blk_pos_t'(2*p + 1), rand_pixels());
    end
    for (int p = 0; p < 4; p++) begin
      for (int h = 0; h < 2; h++) begin
        next_cycle();
        put_read(SIZE_08, blk_pos_t'(2*p), blk_pos_t'(2*p), rd_idx_t'(4*h));
      end
    end

    test_name = "random_mix";
    for (int n = 0; n < NUM_RAND; n++) begin
      next_cycle();
      op = $urandom_range(3);
      if (op[0]) begin
        put_read(blk_size_e'($urandom_range(3, 1)), blk_pos_t'($urandom),
                 blk_pos_t'($urandom), rd_idx_t'($urandom));
      end
      if (op[1]) begin
        put_write(blk_size_e'($urandom_range(3)), blk_pos_t'($urandom),
                  blk_pos_t'($urandom), rand_pixels());
      end
    end

    // let the last read reach the compare process
    repeat (3) next_cycle();

    if (n_checks > 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "no read data was compared");
    end
  end

endmodule
